// ==== common/ring_l2_pkg.sv ====
// Ring packet types, packet struct, L2 address union and cache line constants
package ring_l2_pkg;

	// A line is four 32-bit words, moved as one unit on the ring and in the store
	localparam int word_bits = 32;
	localparam int line_words = 4;
	localparam int line_bits = line_words * word_bits;

	// Packet types seen on the ring
	// Only the first three are requests that an L2 bank may claim
	typedef enum logic [1:0]
	{
		pkt_read_shared,
		pkt_write_invalidate,
		pkt_l2_writeback,
		pkt_other
	} packet_type_t;

	// Node view of an address, used by a bank to decide whether a packet is its own
	typedef struct packed
	{
		logic [22:0] tag;
		logic [3:0] set_idx;
		logic bank;
		logic [3:0] offset;
	} l2_node_addr_t;

	// Store view of the same address
	// The line number covers tag, set and bank, so the two banks never share a line
	typedef struct packed
	{
		logic [27:0] line_idx;
		logic [3:0] offset;
	} l2_store_addr_t;

	// One address word, read either by the ring node or by the line store
	typedef union packed
	{
		l2_node_addr_t node;
		l2_store_addr_t store;
	} l2_addr_u;

	// One ring slot
	// A slot with valid low is empty and its other fields carry no meaning
	typedef struct packed
	{
		logic valid;
		packet_type_t packet_type;
		// Set on a reply, so a bank never claims its own or another bank's answer
		logic ack;
		// There is no miss path in this model, a reply always has it clear
		logic l2_miss;
		logic [1:0] dest_core;
		logic cache_type;
		l2_addr_u address;
		logic [line_bits-1:0] data;
	} ring_packet_t;

endpackage

// ==== common/line_store_if.sv ====
// Line store access interface with requester, arbiter and store modports
interface line_store_if
	#(parameter int IDX_BITS = 6);

	import ring_l2_pkg::*;

	// Request side, held by the requester until gnt is seen
	logic req;
	logic gnt;
	logic write;
	logic [IDX_BITS-1:0] line_idx;
	logic [line_bits-1:0] wdata;

	// Read return, one cycle after the grant of a read
	logic [line_bits-1:0] rdata;
	logic rvalid;

	// A bank, or the arbiter toward the store
	modport requester
	(
		output req, write, line_idx, wdata,
		input gnt, rdata, rvalid
	);

	// The arbiter facing one bank
	modport arbiter
	(
		input req, write, line_idx, wdata,
		output gnt, rdata, rvalid
	);

	// The memory itself
	modport store
	(
		input req, write, line_idx, wdata,
		output gnt, rdata, rvalid
	);

endinterface

// ==== l2/l2_bank.sv ====
// L2 bank ring node with claim logic, one-entry pending request, store FSM and reply insertion
module l2_bank
	#(
		parameter logic BANK_ID = 1'b0,
		parameter int IDX_BITS = 6
	)
	(
		input logic clk,
		input logic rst_n,
		input ring_l2_pkg::ring_packet_t packet_in,
		output logic in_ready,
		output ring_l2_pkg::ring_packet_t packet_out,
		input logic out_ready,
		line_store_if.requester store
	);

	import ring_l2_pkg::*;

	// Life of one claimed request
	typedef enum logic [1:0]
	{
		st_idle,
		st_req,
		st_wait_data,
		st_wait_slot
	} bank_state_t;

	bank_state_t state;
	ring_packet_t pend_pkt;
	ring_packet_t reply_pkt;
	ring_packet_t next_out;
	logic is_request;
	logic claim_hit;
	logic claim;
	logic pend_write;

	// Requests are the three L2 packet types
	// Replies already carry ack and are never claimed again
	always_comb
	begin
		unique case (packet_in.packet_type)
			pkt_read_shared,
			pkt_write_invalidate,
			pkt_l2_writeback:
				is_request = 1'b1;
			default:
				is_request = 1'b0;
		endcase
	end

	assign claim_hit = packet_in.valid && !packet_in.ack && is_request
		&& packet_in.address.node.bank == BANK_ID;

	// The bank takes nothing from upstream while a request is pending,
	// and it passes back-pressure from downstream straight through
	assign in_ready = out_ready && state == st_idle;
	assign claim = claim_hit && in_ready;

	// Store request fields come straight from the pending packet
	assign pend_write = pend_pkt.packet_type == pkt_l2_writeback;
	assign store.req = state == st_req;
	assign store.write = pend_write;
	assign store.line_idx = pend_pkt.address.store.line_idx[IDX_BITS-1:0];
	assign store.wdata = pend_pkt.data;

	// Control FSM
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= st_idle;
		else
		begin
			unique case (state)
				st_idle:
					if (claim)
						state <= st_req;

				st_req:
				begin
					// A writeback is finished once the store has taken it
					if (store.gnt)
						state <= pend_write ? st_idle : st_wait_data;
				end

				st_wait_data:
					if (store.rvalid)
						state <= st_wait_slot;

				st_wait_slot:
					if (out_ready)
						state <= st_idle;

				default:
					state <= st_idle;
			endcase
		end
	end

	// Pending entry, header from the claim and line data from the store read
	always_ff @(posedge clk)
	begin
		if (claim)
			pend_pkt <= packet_in;
		else if (state == st_wait_data && store.rvalid)
			pend_pkt.data <= store.rdata;
	end

	// The reply keeps type, core, cache type and address of the request
	always_comb
	begin
		reply_pkt = pend_pkt;
		reply_pkt.valid = 1'b1;
		reply_pkt.ack = 1'b1;
		reply_pkt.l2_miss = 1'b0;
	end

	// Next content of the ring slot
	// No upstream packet is accepted outside idle, so the slot is free for the reply
	always_comb
	begin
		next_out = packet_in;
		if (state != st_idle || claim_hit)
			next_out.valid = 1'b0;
		if (state == st_wait_slot)
			next_out = reply_pkt;
	end

	// Output slot register, held while downstream is not ready
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			packet_out.valid <= 1'b0;
		else if (out_ready)
			packet_out <= next_out;
	end

endmodule

// ==== l2/l2_store_arbiter.sv ====
// Round-robin arbiter sharing one line store between two banks, with read return steering
module l2_store_arbiter
	#(parameter int IDX_BITS = 6)
	(
		input logic clk,
		input logic rst_n,
		line_store_if.arbiter bank0,
		line_store_if.arbiter bank1,
		line_store_if.requester store
	);

	// Index of the bank that wins this cycle, and the one that won last time
	logic sel;
	logic last_sel;
	// Bank that wins when both ask
	logic prio;
	logic [IDX_BITS-1:0] mux_idx;
	logic granted;

	// A lone requester always wins, the priority bit only breaks ties
	assign sel = (bank0.req && bank1.req) ? prio : bank1.req;

	// Forward the winner to the store
	assign mux_idx = sel ? bank1.line_idx : bank0.line_idx;
	assign store.req = bank0.req || bank1.req;
	assign store.write = sel ? bank1.write : bank0.write;
	assign store.line_idx = mux_idx;
	assign store.wdata = sel ? bank1.wdata : bank0.wdata;

	// The grant goes back only to the winner, and only if the store took it
	assign granted = store.req && store.gnt;
	assign bank0.gnt = granted && !sel;
	assign bank1.gnt = granted && sel;

	// Read data returns one cycle after its grant
	// The registered winner says which bank it belongs to
	assign bank0.rvalid = store.rvalid && !last_sel;
	assign bank1.rvalid = store.rvalid && last_sel;
	assign bank0.rdata = last_sel ? '0 : store.rdata;
	assign bank1.rdata = last_sel ? store.rdata : '0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			prio <= 1'b0;
			last_sel <= 1'b0;
		end
		else if (granted)
		begin
			// Priority passes to the bank that was not served
			prio <= !sel;
			last_sel <= sel;
		end
	end

endmodule

// ==== l2/line_store.sv ====
// Single-port line-wide memory with registered read and zeroed start contents
module line_store
	#(parameter int MEM_LINES = 64)
	(
		input logic clk,
		input logic rst_n,
		line_store_if.store port
	);

	import ring_l2_pkg::*;

	logic [line_bits-1:0] mem [MEM_LINES];
	int unsigned line_sel;

	// Every line reads as zero until it is first written
	initial
	begin
		for (int i = 0; i < MEM_LINES; i++)
			mem[i] = '0;
	end

	// Line numbers beyond the array fold back onto it
	assign line_sel = int'(port.line_idx) % MEM_LINES;

	// One access per cycle, and the store never refuses one
	assign port.gnt = port.req;

	// Write at the grant edge, or capture the read word for the next cycle
	always_ff @(posedge clk)
	begin
		if (port.req && port.gnt)
		begin
			if (port.write)
				mem[line_sel] <= port.wdata;
			else
				port.rdata <= mem[line_sel];
		end
	end

	// Read strobe, high for the one cycle after a read grant
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			port.rvalid <= 1'b0;
		else
			port.rvalid <= port.req && port.gnt && !port.write;
	end

endmodule

// ==== verilog/ring_l2_top.sv ====
// Top level with two L2 banks chained on the ring, the store arbiter and the line store
module ring_l2_top
	#(parameter int MEM_LINES = 64)
	(
		input logic clk,
		input logic rst_n,
		input ring_l2_pkg::ring_packet_t packet_in,
		output logic in_ready,
		output ring_l2_pkg::ring_packet_t packet_out
	);

	import ring_l2_pkg::*;

	// Wide enough to number every line of the store
	localparam int IDX_BITS = $clog2(MEM_LINES);

	// Ring link between bank 0 and bank 1, ready runs against the packet
	ring_packet_t mid_packet;
	logic mid_ready;

	line_store_if #(.IDX_BITS(IDX_BITS)) bank0_if();
	line_store_if #(.IDX_BITS(IDX_BITS)) bank1_if();
	line_store_if #(.IDX_BITS(IDX_BITS)) mem_if();

	l2_bank #(.BANK_ID(1'b0), .IDX_BITS(IDX_BITS)) i_bank0
	(
		.clk(clk),
		.rst_n(rst_n),
		.packet_in(packet_in),
		.in_ready(in_ready),
		.packet_out(mid_packet),
		.out_ready(mid_ready),
		.store(bank0_if.requester)
	);

	// The ring sink after the last bank never stalls
	l2_bank #(.BANK_ID(1'b1), .IDX_BITS(IDX_BITS)) i_bank1
	(
		.clk(clk),
		.rst_n(rst_n),
		.packet_in(mid_packet),
		.in_ready(mid_ready),
		.packet_out(packet_out),
		.out_ready(1'b1),
		.store(bank1_if.requester)
	);

	l2_store_arbiter #(.IDX_BITS(IDX_BITS)) i_arbiter
	(
		.clk(clk),
		.rst_n(rst_n),
		.bank0(bank0_if.arbiter),
		.bank1(bank1_if.arbiter),
		.store(mem_if.requester)
	);

	line_store #(.MEM_LINES(MEM_LINES)) i_line_store
	(
		.clk(clk),
		.rst_n(rst_n),
		.port(mem_if.store)
	);

endmodule

// ==== verif/ring_l2_asserts.sv ====
// Concurrent assertions on store grants, bank ready and reply fields, and their bind statements
module ring_l2_asserts
	(
		input logic clk,
		input logic rst_n,
		input logic gnt0,
		input logic gnt1,
		input logic claim,
		input logic store_gnt,
		input logic store_write,
		input logic store_rvalid,
		input logic in_valid,
		input logic in_ready,
		input logic out_ready,
		input ring_l2_pkg::ring_packet_t packet_out
	);

	// A request is held from its claim until the store takes a writeback
	// or until the read reply is loaded into the ring slot
	logic held;
	// Read data is back and the reply still waits for a free slot
	logic reply_due;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			held <= 1'b0;
			reply_due <= 1'b0;
		end
		else
		begin
			if (claim)
				held <= 1'b1;
			else if ((store_gnt && store_write) || (reply_due && out_ready))
				held <= 1'b0;
			if (store_rvalid)
				reply_due <= 1'b1;
			else if (out_ready)
				reply_due <= 1'b0;
		end
	end

	// The shared store serves one bank per cycle
	one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt0 && gnt1))
		else $error("both banks granted the line store in one cycle");

	// A bank with a held request takes nothing new from upstream
	no_ready_pending: assert property (@(posedge clk) disable iff (!rst_n) held |-> !in_ready)
		else $error("bank raised in_ready with a request pending");

	// A slot loaded without an upstream transfer is either empty or a reply
	// A reply carries ack and never a miss
	reply_fields: assert property (@(posedge clk) disable iff (!rst_n)
		out_ready && !(in_valid && in_ready)
			|=> !packet_out.valid || (packet_out.ack && !packet_out.l2_miss))
		else $error("reply left the bank without ack or with l2_miss set");

endmodule

// Arbiter instance checks only the grants
bind l2_store_arbiter ring_l2_asserts i_arbiter_asserts
(
	.clk(clk),
	.rst_n(rst_n),
	.gnt0(bank0.gnt),
	.gnt1(bank1.gnt),
	.claim(1'b0),
	.store_gnt(1'b0),
	.store_write(1'b0),
	.store_rvalid(1'b0),
	.in_valid(1'b0),
	.in_ready(1'b0),
	.out_ready(1'b0),
	.packet_out('0)
);

// Bank instances check ready and replies
bind l2_bank ring_l2_asserts i_bank_asserts
(
	.clk(clk),
	.rst_n(rst_n),
	.gnt0(1'b0),
	.gnt1(1'b0),
	.claim(claim),
	.store_gnt(store.gnt),
	.store_write(store.write),
	.store_rvalid(store.rvalid),
	.in_valid(packet_in.valid),
	.in_ready(in_ready),
	.out_ready(out_ready),
	.packet_out(packet_out)
);

// ==== verif/ring_l2_tb.sv ====
// Testbench for the ring L2 top level with LFSR stimulus, reference line model and scoreboard
module ring_l2_tb;

	import ring_l2_pkg::*;

	localparam int mem_lines = 64;
	localparam int wait_limit = 300;

	logic clk;
	logic rst_n;
	ring_packet_t packet_in;
	logic in_ready;
	ring_packet_t packet_out;

	logic [15:0] lfsr;
	logic [line_bits-1:0] model_mem [mem_lines];
	// Replies and pass-through packets still expected on packet_out
	ring_packet_t exp_q [$];
	int match_idx;
	int errors;
	int checks;
	int out_count;
	int tests_run;
	int start_errors;
	int start_count;
	int reads_sent;
	ring_packet_t pkt;

	ring_l2_top #(.MEM_LINES(mem_lines)) i_ring_l2_top
	(
		.clk(clk),
		.rst_n(rst_n),
		.packet_in(packet_in),
		.in_ready(in_ready),
		.packet_out(packet_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois LFSR, one step for every bit handed out
	function automatic logic take_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 16'hb400;
		return out;
	endfunction

	function automatic logic [line_bits-1:0] take_bits(input int n);
		logic [line_bits-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[line_bits-2:0], take_bit()};
		return v;
	endfunction

	// Address of line set_idx in a bank, with tag and offset zero
	function automatic logic [31:0] line_addr(input logic bank, input logic [3:0] set_idx);
		return {23'h0, set_idx, bank, 4'h0};
	endfunction

	function automatic ring_packet_t make_pkt(input packet_type_t t, input logic [31:0] addr,
		input logic [1:0] core, input logic [line_bits-1:0] data);
		ring_packet_t p;
		p = '0;
		p.valid = 1'b1;
		p.packet_type = t;
		p.dest_core = core;
		p.address = addr;
		p.data = data;
		return p;
	endfunction

	// Reference model of one packet on the ring
	// An invalid result means no packet comes out for this one
	function automatic ring_packet_t predict(input ring_packet_t req);
		ring_packet_t rsp;
		int line;
		rsp = req;
		line = int'(req.address.store.line_idx) % mem_lines;
		// Replies and foreign packets go round untouched
		if (req.ack || req.packet_type == pkt_other)
			return rsp;
		if (req.packet_type == pkt_l2_writeback)
		begin
			model_mem[line] = req.data;
			rsp.valid = 1'b0;
			return rsp;
		end
		rsp.ack = 1'b1;
		rsp.l2_miss = 1'b0;
		rsp.data = model_mem[line];
		return rsp;
	endfunction

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send(input ring_packet_t p);
		ring_packet_t rsp;
		int waits;
		rsp = predict(p);
		if (rsp.valid)
			exp_q.push_back(rsp);
		packet_in = p;
		waits = 0;
		while (!in_ready && waits < wait_limit)
		begin
			@(negedge clk);
			waits++;
		end
		if (!in_ready)
		begin
			$display("Timeout at %0t, in_ready stayed low and a packet was not taken", $time);
			errors++;
		end
		@(negedge clk);
		packet_in.valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waits;
		waits = 0;
		while (exp_q.size() != 0 && waits < wait_limit)
		begin
			@(negedge clk);
			waits++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Timeout at %0t, %0d expected packets never came out", $time, exp_q.size());
			errors++;
			exp_q.delete();
		end
		// A few quiet cycles so a stray packet still shows up in this test
		repeat (6) @(negedge clk);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == start_errors)
			$display("Test %0d %s: ok", tests_run, name);
		else
			$display("Test %0d %s: %0d errors", tests_run, name, errors - start_errors);
		start_errors = errors;
	endtask

	// Scoreboard, a packet matches the oldest entry with its address and dest_core
	always @(posedge clk)
	begin
		if (rst_n && packet_out.valid)
		begin
			out_count++;
			match_idx = -1;
			for (int i = 0; i < exp_q.size(); i++)
				if (match_idx < 0 && exp_q[i].address == packet_out.address
					&& exp_q[i].dest_core == packet_out.dest_core)
					match_idx = i;
			if (match_idx < 0)
			begin
				$display("Unexpected packet at %0t on packet_out, address %h, dest_core %0d",
					$time, packet_out.address, packet_out.dest_core);
				errors++;
			end
			else
			begin
				checks++;
				if (packet_out !== exp_q[match_idx])
				begin
					$display("[FAIL] %0t packet_out expected %h got %h",
						$time, exp_q[match_idx], packet_out);
					errors++;
				end
				exp_q.delete(match_idx);
			end
		end
	end

	initial
	begin
		rst_n = 1'b0;
		packet_in = '0;
		lfsr = 16'd45806;
		errors = 0;
		checks = 0;
		out_count = 0;
		tests_run = 0;
		start_errors = 0;
		for (int i = 0; i < mem_lines; i++)
			model_mem[i] = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Untouched lines in both banks read as zero
		checks++;
		if (in_ready !== 1'b1)
		begin
			$display("[FAIL] %0t in_ready expected 1 got %b", $time, in_ready);
			errors++;
		end
		send(make_pkt(pkt_read_shared, line_addr(1'b0, 4'h1), 2'd1, '0));
		send(make_pkt(pkt_read_shared, line_addr(1'b1, 4'h1), 2'd2, '0));
		wait_drain();
		end_test("read untouched lines");

		// Writeback then read back, the writeback itself stays silent
		send(make_pkt(pkt_l2_writeback, line_addr(1'b0, 4'h2), 2'd0, take_bits(line_bits)));
		send(make_pkt(pkt_read_shared, line_addr(1'b0, 4'h2), 2'd3, '0));
		send(make_pkt(pkt_l2_writeback, line_addr(1'b1, 4'h2), 2'd1, take_bits(line_bits)));
		send(make_pkt(pkt_read_shared, line_addr(1'b1, 4'h2), 2'd1, '0));
		wait_drain();
		end_test("writeback and read");

		// The request data of a write-invalidate is not stored
		send(make_pkt(pkt_write_invalidate, line_addr(1'b1, 4'h2), 2'd2, take_bits(line_bits)));
		wait_drain();
		end_test("write invalidate");

		// Acked packets and foreign types pass and leave the store alone
		pkt = make_pkt(pkt_l2_writeback, line_addr(1'b0, 4'h2), 2'd2, take_bits(line_bits));
		pkt.ack = 1'b1;
		send(pkt);
		pkt = make_pkt(pkt_read_shared, line_addr(1'b1, 4'h6), 2'd0, take_bits(line_bits));
		pkt.ack = 1'b1;
		send(pkt);
		send(make_pkt(pkt_other, line_addr(1'b1, 4'h2), 2'd3, take_bits(line_bits)));
		wait_drain();
		send(make_pkt(pkt_read_shared, line_addr(1'b0, 4'h2), 2'd0, '0));
		send(make_pkt(pkt_read_shared, line_addr(1'b1, 4'h2), 2'd0, '0));
		wait_drain();
		end_test("pass through");

		// Random back-to-back mix over both banks
		start_count = out_count;
		reads_sent = 0;
		for (int n = 0; n < 200; n++)
		begin
			if (take_bit())
				pkt = make_pkt(pkt_l2_writeback, 32'(take_bits(32)), 2'd0,
					take_bits(line_bits));
			else
			begin
				pkt = make_pkt(pkt_read_shared, 32'(take_bits(32)), 2'd0, '0);
				reads_sent++;
			end
			pkt.dest_core = 2'(take_bits(2));
			pkt.cache_type = take_bit();
			send(pkt);
		end
		wait_drain();
		checks++;
		if (out_count - start_count != reads_sent)
		begin
			$display("[FAIL] %0t reply count expected %0d got %0d",
				$time, reads_sent, out_count - start_count);
			errors++;
		end
		end_test("random mix");

		// A second request to a busy bank is held off by in_ready
		send(make_pkt(pkt_read_shared, line_addr(1'b0, 4'h3), 2'd1, '0));
		checks++;
		if (in_ready !== 1'b0)
		begin
			$display("[FAIL] %0t in_ready expected 0 got %b", $time, in_ready);
			errors++;
		end
		send(make_pkt(pkt_read_shared, line_addr(1'b0, 4'h5), 2'd2, '0));
		wait_drain();
		end_test("back pressure");

		$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== ring_l2.f ====
common/ring_l2_pkg.sv
common/line_store_if.sv
l2/l2_bank.sv
l2/l2_store_arbiter.sv
l2/line_store.sv
verilog/ring_l2_top.sv
verif/ring_l2_asserts.sv
verif/ring_l2_tb.sv
